/* Bender.yml */
package:
  name: iso_bridge

export_include_dirs:
  - logic

sources:
  # RTL in compile order, the package first
  - include_dirs:
      - logic
    files:
      - logic/iso_bridge_pkg.sv
      - logic/reg_bank_if.sv
      - logic/isochronous_spill_register.sv
      - logic/reg_bank.sv
      - logic/cmd_ctrl.sv
      - logic/iso_bridge_top.sv

  # Testbench, top module tb_iso_bridge
  - target: test
    include_dirs:
      - logic
    files:
      - test/tb_iso_bridge.sv

/* logic/cmd_ctrl.sv */
/*
 * Command controller in the destination domain.
 * Reads the addressed register, replies with its old value, then commits.
 */

`timescale 1ns/1ps

module cmd_ctrl import iso_bridge_pkg::*; (
  input  logic     dst_clk_i,
  input  logic     reset_i,
  // Command side, fed by the command buffer
  input  iso_cmd_t cmd_i,
  input  logic     cmd_valid_i,
  output logic     cmd_ready_o,
  // Response side, towards the response buffer
  output iso_rsp_t rsp_o,
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i,
  // Register bank access
  reg_bank_if.ctrl bank
);

  // FETCH issues the read, REPLY holds the response until it is taken
  typedef enum logic {
    FETCH,
    REPLY
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   is_write;
  logic   is_add;
  logic   rsp_accept;

  // Opcode decode, reads and the reserved code both fall to the default
  always_comb begin
    is_write = 1'b0;
    is_add   = 1'b0;
    case (cmd_i.op)
      ISO_OP_WRITE: is_write = 1'b1;
      ISO_OP_ADD:   is_add = 1'b1;
      default:      is_write = 1'b0;
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      FETCH: begin
        if (cmd_valid_i) begin
          state_d = REPLY;
        end
      end
      REPLY: begin
        if (rsp_ready_i) begin
          state_d = FETCH;
        end
      end
      default: state_d = FETCH;
    endcase
  end

  always_ff @(posedge dst_clk_i) begin
    if (reset_i) begin
      state_q <= FETCH;
    end else begin
      state_q <= state_d;
    end
  end

  // The command stays in the buffer until its response is handed off
  // This keeps cmd_i stable for the whole REPLY state
  assign rsp_accept  = (state_q == REPLY) && rsp_ready_i;
  assign cmd_ready_o = rsp_accept;

  // Read the old value as soon as a command shows up
  assign bank.rd_en   = (state_q == FETCH) && cmd_valid_i;
  assign bank.rd_addr = cmd_i.addr;

  // Side effects happen only once, on the cycle the response is accepted
  assign bank.wr_en   = rsp_accept && (is_write || is_add);
  assign bank.wr_add  = is_add;
  assign bank.wr_addr = cmd_i.addr;
  assign bank.wr_data = cmd_i.payload.operand;

  // Reads echo the tag from the read view, writes and adds answer with zero
  assign rsp_valid_o = (state_q == REPLY);
  assign rsp_o.tag   = (is_write || is_add) ? '0 : cmd_i.payload.rd.tag;
  assign rsp_o.data  = bank.rd_data;

endmodule

/* logic/iso_bridge_cfg.svh */
/*
 * Isochronous register bridge configuration.
 * Widths and sizes shared by the package, the bank and the top level.
 */

`ifndef ISO_BRIDGE_CFG_SVH
`define ISO_BRIDGE_CFG_SVH

// Width of one bank register and of a write or add operand
`define ISO_DATA_W 16

// Width of the tag that a read echoes back in its response
// It occupies the upper part of the payload in the read view
`define ISO_TAG_W 8

// Number of registers in the bank, a power of two
`define ISO_REG_NUM 8

`endif

/* logic/iso_bridge_pkg.sv */
/*
 * Isochronous register bridge types.
 * Opcode, payload views, and the command and response words.
 */

`include "iso_bridge_cfg.svh"

package iso_bridge_pkg;

  // Address width follows from the register count
  localparam int unsigned ISO_ADDR_W = $clog2(`ISO_REG_NUM);

  typedef logic [ISO_ADDR_W-1:0] iso_addr_t;
  typedef logic [`ISO_DATA_W-1:0] iso_data_t;
  typedef logic [`ISO_TAG_W-1:0] iso_tag_t;

  // The reserved code is executed as a read by the controller
  typedef enum logic [1:0] {
    ISO_OP_READ  = 2'd0,
    ISO_OP_WRITE = 2'd1,
    ISO_OP_ADD   = 2'd2,
    ISO_OP_RSVD  = 2'd3
  } iso_op_e;

  // Read view of the payload: tag on top, unused bits below
  typedef struct packed {
    iso_tag_t                           tag;
    logic [`ISO_DATA_W-`ISO_TAG_W-1:0] rsvd;
  } iso_read_view_t;

  // Writes and adds see the whole word as the operand
  typedef union packed {
    iso_data_t      operand;
    iso_read_view_t rd;
  } iso_payload_u;

  typedef struct packed {
    iso_op_e      op;
    iso_addr_t    addr;
    iso_payload_u payload;
  } iso_cmd_t;

  // Data always carries the register value from before the command
  typedef struct packed {
    iso_tag_t  tag;
    iso_data_t data;
  } iso_rsp_t;

endpackage

/* logic/iso_bridge_top.sv */
/*
 * Isochronous register bridge top level.
 * Commands cross from the source clock to the bank and responses cross back.
 */

`timescale 1ns/1ps

`include "iso_bridge_cfg.svh"

module iso_bridge_top import iso_bridge_pkg::*; (
  input  logic                   src_clk_i,
  input  logic                   dst_clk_i,
  input  logic                   reset_i,
  // Command in, source clock domain
  input  logic                   cmd_valid_i,
  output logic                   cmd_ready_o,
  input  logic [1:0]             cmd_op_i,
  input  logic [ISO_ADDR_W-1:0]  cmd_addr_i,
  input  logic [`ISO_DATA_W-1:0] cmd_payload_i,
  // Response out, source clock domain
  output logic                   rsp_valid_o,
  input  logic                   rsp_ready_i,
  output logic [`ISO_TAG_W-1:0]  rsp_tag_o,
  output logic [`ISO_DATA_W-1:0] rsp_data_o
);

  // Command word on either side of the crossing
  iso_cmd_t src_cmd;
  iso_cmd_t dst_cmd;
  logic     dst_cmd_valid;
  logic     dst_cmd_ready;

  // Response word on either side of the crossing
  iso_rsp_t dst_rsp;
  iso_rsp_t src_rsp;
  logic     dst_rsp_valid;
  logic     dst_rsp_ready;

  reg_bank_if bank_if ();

  // Pack the flat command ports into one word
  assign src_cmd.op      = iso_op_e'(cmd_op_i);
  assign src_cmd.addr    = cmd_addr_i;
  assign src_cmd.payload = cmd_payload_i;

  isochronous_spill_register #(
    .T (iso_cmd_t)
  ) u_cmd_spill (
    .src_clk_i   (src_clk_i),
    .src_valid_i (cmd_valid_i),
    .src_ready_o (cmd_ready_o),
    .src_data_i  (src_cmd),
    .dst_clk_i   (dst_clk_i),
    .dst_valid_o (dst_cmd_valid),
    .dst_ready_i (dst_cmd_ready),
    .dst_data_o  (dst_cmd),
    .reset_i     (reset_i)
  );

  cmd_ctrl u_cmd_ctrl (
    .dst_clk_i   (dst_clk_i),
    .reset_i     (reset_i),
    .cmd_i       (dst_cmd),
    .cmd_valid_i (dst_cmd_valid),
    .cmd_ready_o (dst_cmd_ready),
    .rsp_o       (dst_rsp),
    .rsp_valid_o (dst_rsp_valid),
    .rsp_ready_i (dst_rsp_ready),
    .bank        (bank_if)
  );

  reg_bank u_reg_bank (
    .dst_clk_i (dst_clk_i),
    .reset_i   (reset_i),
    .bank      (bank_if)
  );

  // Response buffer runs the other way, its source side is the bank clock
  isochronous_spill_register #(
    .T (iso_rsp_t)
  ) u_rsp_spill (
    .src_clk_i   (dst_clk_i),
    .src_valid_i (dst_rsp_valid),
    .src_ready_o (dst_rsp_ready),
    .src_data_i  (dst_rsp),
    .dst_clk_i   (src_clk_i),
    .dst_valid_o (rsp_valid_o),
    .dst_ready_i (rsp_ready_i),
    .dst_data_o  (src_rsp),
    .reset_i     (reset_i)
  );

  assign rsp_tag_o  = src_rsp.tag;
  assign rsp_data_o = src_rsp.data;

endmodule

/* logic/isochronous_spill_register.sv */
/*
 * Two-entry handshake buffer between two clocks derived from one root.
 * Cuts every combinational path between the sides and relies on static timing.
 */

`timescale 1ns/1ps

module isochronous_spill_register #(
  parameter type T = logic
) (
  // Source side
  input  logic src_clk_i,
  input  logic src_valid_i,
  output logic src_ready_o,
  input  T     src_data_i,
  // Destination side
  input  logic dst_clk_i,
  output logic dst_valid_o,
  input  logic dst_ready_i,
  output T     dst_data_o,
  // Sampled separately by each side on its own clock
  input  logic reset_i
);

  // Both pointers carry one extra bit above the entry index
  // Equal pointers mean empty
  // Pointers that differ only in the top bit mean both entries are taken
  logic [1:0] wr_ptr_q;
  logic [1:0] rd_ptr_q;
  logic       push;
  logic       pop;

  // Entry storage lives in the source domain and is read across by the sink
  T mem_q [2];

  assign push = src_valid_i && src_ready_o;
  assign pop  = dst_valid_o && dst_ready_i;

  // Write pointer belongs to the source clock
  always_ff @(posedge src_clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
    end else if (push) begin
      wr_ptr_q <= wr_ptr_q + 2'd1;
    end
  end

  always_ff @(posedge src_clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q[0]] <= src_data_i;
    end
  end

  // Read pointer belongs to the destination clock
  always_ff @(posedge dst_clk_i) begin
    if (reset_i) begin
      rd_ptr_q <= '0;
    end else if (pop) begin
      rd_ptr_q <= rd_ptr_q + 2'd1;
    end
  end

  // Ready drops only while both entries are occupied
  assign src_ready_o = (wr_ptr_q ^ rd_ptr_q) != 2'b10;

  // Anything other than equal pointers leaves at least one item to deliver
  assign dst_valid_o = (wr_ptr_q ^ rd_ptr_q) != 2'b00;
  assign dst_data_o  = mem_q[rd_ptr_q[0]];

endmodule

/* logic/reg_bank.sv */
/*
 * Destination-domain register file.
 * Registered read port, write port that stores or accumulates.
 */

`timescale 1ns/1ps

`include "iso_bridge_cfg.svh"

module reg_bank import iso_bridge_pkg::*; (
  input  logic     dst_clk_i,
  input  logic     reset_i,
  reg_bank_if.bank bank
);

  iso_data_t regs_q [`ISO_REG_NUM];
  iso_data_t wr_sum;
  iso_data_t wr_value;

  // Sum is truncated to the register width, so adds wrap around
  assign wr_sum = regs_q[bank.wr_addr] + bank.wr_data;

  // An add accumulates into the addressed register, a plain write replaces it
  assign wr_value = bank.wr_add ? wr_sum : bank.wr_data;

  // All registers start at zero
  always_ff @(posedge dst_clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `ISO_REG_NUM; i++) begin
        regs_q[i] <= '0;
      end
    end else if (bank.wr_en) begin
      regs_q[bank.wr_addr] <= wr_value;
    end
  end

  // Read data is captured on rd_en and then held
  // The controller reads it back while it waits for the response handshake
  always_ff @(posedge dst_clk_i) begin
    if (bank.rd_en) begin
      bank.rd_data <= regs_q[bank.rd_addr];
    end
  end

endmodule

/* logic/reg_bank_if.sv */
/*
 * Register bank access interface.
 * One registered read port and one store-or-add write port.
 */

`timescale 1ns/1ps

interface reg_bank_if import iso_bridge_pkg::*; ();

  // Read request and the value it returns one cycle later
  logic      rd_en;
  iso_addr_t rd_addr;
  iso_data_t rd_data;

  // Write request, wr_add selects accumulate instead of store
  logic      wr_en;
  logic      wr_add;
  iso_addr_t wr_addr;
  iso_data_t wr_data;

  modport ctrl (
    output rd_en, rd_addr, wr_en, wr_add, wr_addr, wr_data,
    input  rd_data
  );

  modport bank (
    input  rd_en, rd_addr, wr_en, wr_add, wr_addr, wr_data,
    output rd_data
  );

endinterface

/* project.f */
+incdir+logic
logic/iso_bridge_pkg.sv
logic/reg_bank_if.sv
logic/isochronous_spill_register.sv
logic/reg_bank.sv
logic/cmd_ctrl.sv
logic/iso_bridge_top.sv
test/tb_iso_bridge.sv

/* test/tb_iso_bridge.sv */
/*
 * Testbench for the isochronous register bridge.
 * Random commands are checked against a register model, with response back-pressure.
 */

`timescale 1ns/1ps

module tb_iso_bridge import iso_bridge_pkg::*; ();

  localparam int SRC_PERIOD = 10;
  // Source clock cycles per destination clock cycle
  localparam int CLK_RATIO = 2;
  localparam int STREAM_CMDS = 300;
  // Directed tests issue 8, 24, 18 and 5 commands before the random stream
  localparam int TOTAL_CMDS = 55 + STREAM_CMDS;
  localparam int BP_WINDOW = 60;
  localparam int DRAIN_LIMIT = 400;

  // Modes of the response ready process
  localparam int RDY_LOW = 0;
  localparam int RDY_HIGH = 1;
  localparam int RDY_RANDOM = 2;

  logic        src_clk_i = 1'b0;
  logic        dst_clk_i = 1'b0;
  logic        reset_i;
  logic        cmd_valid_i;
  logic        cmd_ready_o;
  logic [1:0]  cmd_op_i;
  logic [2:0]  cmd_addr_i;
  logic [15:0] cmd_payload_i;
  logic        rsp_valid_o;
  logic        rsp_ready_i;
  logic [7:0]  rsp_tag_o;
  logic [15:0] rsp_data_o;

  integer      seed = 32'hbd50_d478;
  int          rdy_mode = RDY_HIGH;
  int          error_count = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          accept_count = 0;
  int          div_cnt = 0;

  // Register model and the responses it expects in arrival order
  // Each entry is the tag on top of the data
  logic [15:0] model_regs [8];
  logic [23:0] exp_q [$];

  // Response seen on the last edge while the outside held ready low
  logic        stall_q = 1'b0;
  logic [7:0]  held_tag;
  logic [15:0] held_data;

  always #(SRC_PERIOD / 2) src_clk_i = ~src_clk_i;

  // Destination clock is divided down from the source clock so the edges line up
  // It toggles in the same step as the source edge, before any flop updates
  always @(posedge src_clk_i) begin
    if (div_cnt == CLK_RATIO / 2 - 1) begin
      div_cnt = 0;
      dst_clk_i = ~dst_clk_i;
    end else begin
      div_cnt = div_cnt + 1;
    end
  end

  iso_bridge_top iso_bridge_top_i (
    .src_clk_i     (src_clk_i),
    .dst_clk_i     (dst_clk_i),
    .reset_i       (reset_i),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_ready_o   (cmd_ready_o),
    .cmd_op_i      (cmd_op_i),
    .cmd_addr_i    (cmd_addr_i),
    .cmd_payload_i (cmd_payload_i),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_ready_i   (rsp_ready_i),
    .rsp_tag_o     (rsp_tag_o),
    .rsp_data_o    (rsp_data_o)
  );

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      error_count++;
      $display("ERROR at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
    end
  endtask

  // The old value always comes back but only reads and the reserved code echo the tag
  task automatic apply_model(input logic [1:0] op, input logic [2:0] addr,
                             input logic [15:0] payload);
    logic [15:0] old_value;
    old_value = model_regs[addr];
    case (op)
      ISO_OP_WRITE: begin
        exp_q.push_back({8'h00, old_value});
        model_regs[addr] = payload;
      end
      ISO_OP_ADD: begin
        exp_q.push_back({8'h00, old_value});
        model_regs[addr] = old_value + payload;
      end
      default: exp_q.push_back({payload[15:8], old_value});
    endcase
  endtask

  // Edge monitor that sees the values the DUT samples on this edge
  always @(posedge src_clk_i) begin
    logic [23:0] exp_rsp;
    if (!reset_i) begin
      // A stalled response must hold still until it is taken
      if (stall_q) begin
        check_value("rsp_valid_o (held)", 1, rsp_valid_o);
        check_value("rsp_tag_o (held)", held_tag, rsp_tag_o);
        check_value("rsp_data_o (held)", held_data, rsp_data_o);
      end
      if (rsp_valid_o === 1'b1 && rsp_ready_i === 1'b1) begin
        if (exp_q.size() == 0) begin
          error_count++;
          $display("Response at %0t arrived with no command outstanding", $time);
        end else begin
          exp_rsp = exp_q.pop_front();
          check_value("rsp_tag_o", exp_rsp[23:16], rsp_tag_o);
          check_value("rsp_data_o", exp_rsp[15:0], rsp_data_o);
        end
      end
      // Responses return in command order, so the model advances at acceptance
      if (cmd_valid_i === 1'b1 && cmd_ready_o === 1'b1) begin
        accept_count++;
        apply_model(cmd_op_i, cmd_addr_i, cmd_payload_i);
      end
      stall_q   = (rsp_valid_o === 1'b1) && (rsp_ready_i === 1'b0);
      held_tag  = rsp_tag_o;
      held_data = rsp_data_o;
    end
  end

  always @(negedge src_clk_i) begin
    case (rdy_mode)
      RDY_LOW:  rsp_ready_i = 1'b0;
      RDY_HIGH: rsp_ready_i = 1'b1;
      default:  rsp_ready_i = ($random(seed) & 3) != 0;
    endcase
  end

  // Holds the command until the DUT takes it and returns with valid still high
  task automatic send_cmd(input logic [1:0] op, input logic [2:0] addr,
                          input logic [15:0] payload);
    @(negedge src_clk_i);
    cmd_valid_i   = 1'b1;
    cmd_op_i      = op;
    cmd_addr_i    = addr;
    cmd_payload_i = payload;
    @(posedge src_clk_i);
    while (cmd_ready_o !== 1'b1) begin
      @(posedge src_clk_i);
    end
  endtask

  task automatic send_random_cmd();
    logic [31:0] rnd;
    logic [31:0] data;
    rnd  = $random(seed);
    data = $random(seed);
    send_cmd(rnd[1:0], rnd[4:2], data[15:0]);
  endtask

  task automatic release_cmd();
    @(negedge src_clk_i);
    cmd_valid_i = 1'b0;
  endtask

  // Waits for every expected response, then idles so an extra one would show
  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < DRAIN_LIMIT) begin
      @(negedge src_clk_i);
      cycles++;
    end
    check_value("pending responses", 0, exp_q.size());
    exp_q.delete();
    repeat (20) @(negedge src_clk_i);
  endtask

  task automatic finish_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
      tests_passed++;
      $display("Test %s: PASS", name);
    end else begin
      tests_failed++;
      $display("Test %s: FAIL with %0d errors", name, error_count - errors_before);
    end
  endtask

  initial begin
    int errors_before;
    int base_count;
    int i;
    logic [31:0] rnd;
    logic [31:0] data;
    reset_i       = 1'b1;
    cmd_valid_i   = 1'b0;
    cmd_op_i      = 2'd0;
    cmd_addr_i    = 3'd0;
    cmd_payload_i = 16'h0000;
    rsp_ready_i   = 1'b0;
    for (i = 0; i < 8; i++) begin
      model_regs[i] = 16'h0000;
    end
    repeat (2) @(posedge src_clk_i);
    @(negedge src_clk_i);
    reset_i = 1'b0;

    // Checks the idle handshake state and then reads every register back as zero
    errors_before = error_count;
    check_value("cmd_ready_o", 1, cmd_ready_o);
    check_value("rsp_valid_o", 0, rsp_valid_o);
    for (i = 0; i < 8; i++) begin
      rnd = $random(seed);
      send_cmd(ISO_OP_READ, i[2:0], rnd[15:0]);
    end
    release_cmd();
    wait_drain();
    finish_test("reset state", errors_before);

    errors_before = error_count;
    for (i = 0; i < 16; i++) begin
      rnd  = $random(seed);
      data = $random(seed);
      send_cmd(ISO_OP_WRITE, rnd[2:0], data[15:0]);
    end
    for (i = 0; i < 8; i++) begin
      rnd = $random(seed);
      send_cmd(ISO_OP_READ, i[2:0], rnd[15:0]);
    end
    release_cmd();
    wait_drain();
    finish_test("write then read", errors_before);

    // Each add is followed by a read of the same register to see the wrapped sum
    errors_before = error_count;
    for (i = 0; i < 8; i++) begin
      rnd  = $random(seed);
      data = $random(seed);
      send_cmd(ISO_OP_ADD, rnd[2:0], data[15:0]);
      send_cmd(ISO_OP_READ, rnd[2:0], data[31:16]);
    end
    for (i = 0; i < 2; i++) begin
      rnd = $random(seed);
      send_cmd(ISO_OP_RSVD, rnd[2:0], rnd[31:16]);
    end
    release_cmd();
    wait_drain();
    finish_test("add and reserved opcode", errors_before);

    // Four commands fill both buffers and the controller and the fifth must wait
    errors_before = error_count;
    rdy_mode = RDY_LOW;
    base_count = accept_count;
    fork
      begin
        for (i = 0; i < 5; i++) begin
          send_random_cmd();
        end
        release_cmd();
      end
      begin
        repeat (BP_WINDOW) @(negedge src_clk_i);
        check_value("accepted commands", 4, accept_count - base_count);
        check_value("cmd_ready_o", 0, cmd_ready_o);
        @(posedge src_clk_i);
        rdy_mode = RDY_HIGH;
      end
    join
    wait_drain();
    finish_test("back-pressure", errors_before);

    // The driver draws its random values on rising edges so that it never
    // shares a time step with the ready process, which draws on falling ones
    errors_before = error_count;
    rdy_mode = RDY_RANDOM;
    @(posedge src_clk_i);
    for (i = 0; i < STREAM_CMDS; i++) begin
      send_random_cmd();
      rnd = $random(seed);
      if (rnd[2:0] == 3'd0) begin
        release_cmd();
        repeat (rnd[5:4] + 1) @(posedge src_clk_i);
      end
    end
    release_cmd();
    wait_drain();
    finish_test("random stream", errors_before);

    $display("Tests passed: %0d, failed: %0d, errors: %0d", tests_passed, tests_failed,
             error_count);
    if (tests_failed == 0 && error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Limit of forty source cycles for each command over all the tests
  initial begin
    #(TOTAL_CMDS * 40 * SRC_PERIOD);
    $display("Watchdog timeout: the tests did not finish within %0d source cycles",
             TOTAL_CMDS * 40);
    $display("Simulation failed");
    $finish;
  end

endmodule
